// ==== verif/bus_input.txt ====
# op addr data size back; W write, R read and compare data, E write that expects an error
# P pins as {sd_cd, sd_wp, gpi}, A aux_reset pulse, G expected gpo, S wait for sys_ready
S 00000000 00000000 0 0
W 80000000 11223344 2 0
W 80000004 a5a5a5a5 2 1
W 800003fc deadbeef 2 1
R 80000000 11223344 2 0
R 80000004 a5a5a5a5 2 1
R 800003fc deadbeef 2 1
# byte on lane 1, half on lanes 3 and 2, byte on lane 3
W 80000001 00007700 0 0
W 80000006 bbcc0000 1 1
W 800003ff 12000000 0 1
R 80000000 11227744 2 0
R 80000004 bbcca5a5 2 1
R 800003fc 12adbeef 2 1
# enable, output, then a byte write to the enable register
W 10060004 0000001f 2 0
W 10060008 00000015 2 1
G 00000000 00000015 0 0
W 10060004 0000000f 0 0
G 00000000 00000005 0 0
R 10060004 0000000f 2 0
P 00000000 0000003a 0 0
R 10060000 0000006a 2 0
R 1006000c 00000000 2 1
# unmapped and oversize writes
E 40000000 ffffffff 2 0
E 80000000 ffffffff 3 1
R 80000000 11227744 2 0
A 00000000 00000000 0 0
S 00000000 00000000 0 0
G 00000000 00000000 0 0
R 10060008 00000000 2 0
R 800003fc 12adbeef 2 1

// ==== verilog.f ====
rtl/fpga_pkg.sv
rtl/reset_sequencer.sv
rtl/ahb_bridge.sv
rtl/ext_ram.sv
rtl/gpio_regs.sv
rtl/fpga_top.sv
verif/bus_checker.sv
verif/tb_fpga_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with verilator from the project root and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_fpga_top -f verilog.f &&
./obj_dir/Vtb_fpga_top | tee /dev/stderr | grep -q "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verif/tb_fpga_top.sv ====
// reads verif/bus_input.txt relative to the working directory; every transfer is single
`timescale 1ns/10ps
`default_nettype none

module tb_fpga_top;

  // one line of the stimulus file
  typedef struct packed {
    logic [7:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [2:0] size;
    logic back;
  } step_t;

  logic clk;
  logic rst_n;
  logic aux_reset;
  logic hsel;
  logic [31:0] haddr;
  logic [1:0] htrans;
  logic hwrite;
  logic [2:0] hsize;
  logic [31:0] hwdata;
  logic hready;
  logic hreadyout;
  logic [31:0] hrdata;
  logic hresp;
  logic [3:0] gpi;
  logic sd_cd;
  logic sd_wp;
  logic [4:0] gpo;
  logic sys_ready;
  logic exp_read;
  logic exp_err;
  logic [1:0] exp_waits;
  logic [31:0] exp_data;
  logic gpo_check;
  logic [4:0] exp_gpo;
  logic reset_check;
  int cycle_limit;
  int errors;
  int checks;
  logic timed_out;
  int tb_errors;
  logic [31:0] lfsr;
  step_t steps[$];

  always #50 clk = ~clk;

  fpga_top dut0 (
    .cpu_clk(clk), .rst_n(rst_n), .aux_reset(aux_reset),
    .hsel(hsel), .haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hsize(hsize),
    .hwdata(hwdata), .hready(hready), .hreadyout(hreadyout), .hrdata(hrdata),
    .hresp(hresp), .gpi(gpi), .sd_cd(sd_cd), .sd_wp(sd_wp), .gpo(gpo),
    .sys_ready(sys_ready)
  );

  bus_checker check0 (
    .clk(clk), .rst_n(rst_n), .hsel(hsel), .htrans(htrans), .hready(hready),
    .hreadyout(hreadyout), .hresp(hresp), .hrdata(hrdata), .gpo(gpo),
    .sys_ready(sys_ready), .exp_read(exp_read), .exp_err(exp_err),
    .exp_waits(exp_waits), .exp_data(exp_data), .gpo_check(gpo_check),
    .exp_gpo(exp_gpo), .reset_check(reset_check), .cycle_limit(cycle_limit),
    .errors(errors), .checks(checks), .timed_out(timed_out)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic idle_gap();
    int gap;
    gap = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_next(lfsr);
      gap = gap * 2 + int'(lfsr[0]);
    end
    repeat (gap) @(negedge clk);
  endtask

  task automatic load_steps();
    int fd;
    int n;
    string line;
    logic [7:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    int size;
    int back;
    step_t s;
    fd = $fopen("verif/bus_input.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/bus_input.txt");
      tb_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if ((line.len() > 1) && (line.substr(0, 0) != "#")) begin
          n = $sscanf(line, "%c %h %h %d %d", op, addr, data, size, back);
          if (n == 5) begin
            s.op = op;
            s.addr = addr;
            s.data = data;
            s.size = size[2:0];
            s.back = back[0];
            steps.push_back(s);
          end else begin
            $display("a line of verif/bus_input.txt could not be read: %s", line);
            tb_errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // lets the open data phase end with the bus idle
  task automatic finish_transfer();
    while (!hreadyout) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic pulse_reset_check();
    reset_check = 1'b1;
    @(negedge clk);
    reset_check = 1'b0;
  endtask

  task automatic run_transfer(input step_t s);
    if (!s.back) begin
      idle_gap();
    end
    hsel = 1'b1;
    haddr = s.addr;
    htrans = fpga_pkg::htrans_nonseq;
    hwrite = (s.op != "R");
    hsize = s.size;
    exp_read = (s.op == "R");
    exp_err = (s.op == "E");
    exp_waits = (s.op == "W") ? 2'd0 : 2'd1;
    exp_data = s.data;
    while (!hreadyout) @(negedge clk);
    @(negedge clk);
    // now in the data phase of this transfer
    hwdata = s.data;
    hsel = 1'b0;
    htrans = 2'b00;
  endtask

  task automatic run_step(input step_t s);
    case (s.op)
      "W", "R", "E": run_transfer(s);
      "P": begin
        finish_transfer();
        sd_cd = s.data[5];
        sd_wp = s.data[4];
        gpi = s.data[3:0];
        // let the pins settle through the synchronizer
        repeat (3) @(negedge clk);
      end
      "A": begin
        finish_transfer();
        aux_reset = 1'b1;
        @(negedge clk);
        aux_reset = 1'b0;
        pulse_reset_check();
      end
      "G": begin
        finish_transfer();
        exp_gpo = s.data[4:0];
        gpo_check = 1'b1;
        @(negedge clk);
        gpo_check = 1'b0;
      end
      "S": begin
        finish_transfer();
        while (!sys_ready) @(negedge clk);
      end
      default: begin
        $display("unknown op code %c in verif/bus_input.txt", s.op);
        tb_errors++;
      end
    endcase
  endtask

  task automatic print_counts();
    $display("checks: %0d, checker errors: %0d, testbench errors: %0d",
             checks, errors, tb_errors);
  endtask

  always @(posedge timed_out) begin
    print_counts();
    $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    aux_reset = 1'b0;
    hsel = 1'b0;
    haddr = '0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hsize = 3'b000;
    hwdata = '0;
    hready = 1'b1;
    gpi = 4'h0;
    sd_cd = 1'b0;
    sd_wp = 1'b0;
    exp_read = 1'b0;
    exp_err = 1'b0;
    exp_waits = 2'd0;
    exp_data = '0;
    gpo_check = 1'b0;
    exp_gpo = '0;
    reset_check = 1'b0;
    tb_errors = 0;
    lfsr = 32'h826b8e2d;
    load_steps();
    if (steps.size() == 0) begin
      $display("no stimulus lines were read");
      tb_errors++;
    end
    cycle_limit = steps.size() * 8 + fpga_pkg::calib_cycles + fpga_pkg::rst_hold + 20;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    pulse_reset_check();
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    finish_transfer();
    print_counts();
    if ((errors == 0) && (tb_errors == 0) && (checks > 0)) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/bus_checker.sv ====
// samples only at rising edges; expectations are taken at the edge that accepts a transfer
`timescale 1ns/10ps
`default_nettype none

module bus_checker (
  input  logic clk,
  input  logic rst_n,
  input  logic hsel,
  input  logic [1:0] htrans,
  input  logic hready,
  input  logic hreadyout,
  input  logic hresp,
  input  logic [31:0] hrdata,
  input  logic [4:0] gpo,
  input  logic sys_ready,
  input  logic exp_read,
  input  logic exp_err,
  input  logic [1:0] exp_waits,
  input  logic [31:0] exp_data,
  input  logic gpo_check,
  input  logic [4:0] exp_gpo,
  input  logic reset_check,
  input  int cycle_limit,
  output int errors,
  output int checks,
  output logic timed_out
);

  logic active = 1'b0;
  logic dp_read = 1'b0;
  logic dp_err = 1'b0;
  logic [1:0] dp_waits = 2'd0;
  logic [31:0] dp_data = '0;
  logic [1:0] waits = 2'd0;
  logic timeout_q = 1'b0;
  int cycles = 0;
  int err_cnt = 0;
  int check_cnt = 0;
  logic accept;

  assign errors = err_cnt;
  assign checks = check_cnt;
  assign timed_out = timeout_q;
  assign accept = hsel && (htrans == fpga_pkg::htrans_nonseq) && hready && hreadyout;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!timeout_q && (cycle_limit > 0) && (cycles >= cycle_limit)) begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      timeout_q <= 1'b1;
    end
    //////////////////////////////
    // data phases
    //////////////////////////////
    if (rst_n) begin
      // hresp is high in both cycles of an error and nowhere else
      compare("hresp", {31'b0, hresp}, {31'b0, active && dp_err});
      if (active && !hreadyout) begin
        waits <= waits + 1'b1;
      end else if (active) begin
        compare("wait states", {30'b0, waits}, {30'b0, dp_waits});
        if (dp_read) begin
          compare("hrdata", hrdata, dp_data);
        end
        active <= 1'b0;
      end
      // a new address phase can be taken in the last data phase cycle
      if (accept) begin
        active <= 1'b1;
        dp_read <= exp_read;
        dp_err <= exp_err;
        dp_waits <= exp_waits;
        dp_data <= exp_data;
        waits <= 2'd0;
      end
    end
    //////////////////////////////
    // pins and reset state
    //////////////////////////////
    if (gpo_check) begin
      compare("gpo", {27'b0, gpo}, {27'b0, exp_gpo});
    end
    if (reset_check) begin
      compare("hreadyout", {31'b0, hreadyout}, 32'd1);
      compare("hresp", {31'b0, hresp}, 32'd0);
      compare("gpo", {27'b0, gpo}, 32'd0);
      compare("sys_ready", {31'b0, sys_ready}, 32'd0);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fpga_top.sv ====
// single clock cpu_clk with no mmcm; ram model replaces the ddr pins and controller
`timescale 1ns/10ps
`default_nettype none

module fpga_top (
  input  logic cpu_clk,
  input  logic rst_n,
  input  logic aux_reset,
  // ahb-lite port from the processor
  input  logic hsel,
  input  logic [31:0] haddr,
  input  logic [1:0] htrans,
  input  logic hwrite,
  input  logic [2:0] hsize,
  input  logic [fpga_pkg::data_w-1:0] hwdata,
  input  logic hready,
  output logic hreadyout,
  output logic [fpga_pkg::data_w-1:0] hrdata,
  output logic hresp,
  // gpio pins
  input  logic [3:0] gpi,
  input  logic sd_cd,
  input  logic sd_wp,
  output logic [fpga_pkg::gpo_w-1:0] gpo,
  output logic sys_ready
);

  logic calib_done;
  logic periph_rst_n;
  fpga_pkg::bus_req_t req;
  logic ram_en;
  logic gpio_en;
  logic [fpga_pkg::data_w-1:0] ram_rdata;
  logic [fpga_pkg::data_w-1:0] gpio_rdata;
  logic [fpga_pkg::data_w-1:0] pins_in;

  // card detect and write protect sit above a spare bit and the switches
  assign pins_in = {25'b0, sd_cd, sd_wp, 1'b0, gpi};

  //////////////////////////////
  // reset and ram
  //////////////////////////////
  reset_sequencer seq0 (
    .cpu_clk, .rst_n, .aux_reset, .calib_done,
    .periph_rst_n, .sys_ready
  );

  ext_ram ram0 (
    .cpu_clk, .rst_n, .req, .ram_en, .ram_rdata, .calib_done
  );

  //////////////////////////////
  // bus and peripherals
  //////////////////////////////
  ahb_bridge bridge0 (
    .cpu_clk, .periph_rst_n,
    .hsel, .haddr, .htrans, .hwrite, .hsize, .hwdata, .hready,
    .hreadyout, .hrdata, .hresp,
    .req, .ram_en, .gpio_en, .ram_rdata, .gpio_rdata
  );

  gpio_regs gpio0 (
    .cpu_clk, .periph_rst_n, .req, .gpio_en, .gpio_rdata, .pins_in, .gpo
  );

endmodule

`default_nettype wire

// ==== rtl/gpio_regs.sv ====
// pins are synchronized by two flops; only register indices 0 to 2 exist, the rest read zero
`timescale 1ns/10ps
`default_nettype none

module gpio_regs (
  input  logic cpu_clk,
  input  logic periph_rst_n,
  input  fpga_pkg::bus_req_t req,
  input  logic gpio_en,
  output logic [fpga_pkg::data_w-1:0] gpio_rdata,
  input  logic [fpga_pkg::data_w-1:0] pins_in,
  output logic [fpga_pkg::gpo_w-1:0] gpo
);

  logic [fpga_pkg::data_w-1:0] sync_q;
  logic [fpga_pkg::data_w-1:0] in_reg;
  logic [fpga_pkg::data_w-1:0] en_reg;
  logic [fpga_pkg::data_w-1:0] out_reg;
  logic wr;

  // merge write data into a register per byte strobe
  function automatic logic [fpga_pkg::data_w-1:0] merge_bytes(
    input logic [fpga_pkg::data_w-1:0] old,
    input fpga_pkg::bus_req_t r
  );
    logic [fpga_pkg::data_w-1:0] res;
    res = old;
    for (int b = 0; b < fpga_pkg::strb_w; b++) begin
      if (r.wstrb[b]) begin
        res[8*b +: 8] = r.wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr = gpio_en && req.write;

  //////////////////////////////
  // registers
  //////////////////////////////
  always_ff @(posedge cpu_clk or negedge periph_rst_n) begin
    if (!periph_rst_n) begin
      sync_q <= '0;
      in_reg <= '0;
      en_reg <= '0;
      out_reg <= '0;
    end else begin
      sync_q <= pins_in;
      in_reg <= sync_q;
      if (wr && (req.index == fpga_pkg::gpio_en_reg)) begin
        en_reg <= merge_bytes(en_reg, req);
      end
      if (wr && (req.index == fpga_pkg::gpio_out_reg)) begin
        out_reg <= merge_bytes(out_reg, req);
      end
    end
  end

  // registered read of the selected register
  always_ff @(posedge cpu_clk) begin
    if (gpio_en && !req.write) begin
      case (req.index)
        fpga_pkg::gpio_in_reg: gpio_rdata <= in_reg;
        fpga_pkg::gpio_en_reg: gpio_rdata <= en_reg;
        fpga_pkg::gpio_out_reg: gpio_rdata <= out_reg;
        default: gpio_rdata <= '0;
      endcase
    end
  end

  // disabled pins drive zero
  assign gpo = out_reg[fpga_pkg::gpo_w-1:0] & en_reg[fpga_pkg::gpo_w-1:0];

endmodule

`default_nettype wire

// ==== rtl/ext_ram.sv ====
// stands in for the ddr controller; contents have no reset and survive aux_reset
`timescale 1ns/10ps
`default_nettype none

module ext_ram (
  input  logic cpu_clk,
  input  logic rst_n,
  input  fpga_pkg::bus_req_t req,
  input  logic ram_en,
  output logic [fpga_pkg::data_w-1:0] ram_rdata,
  output logic calib_done
);

  logic [fpga_pkg::data_w-1:0] mem [fpga_pkg::ram_words];
  logic [fpga_pkg::calib_w-1:0] calib_cnt;

  //////////////////////////////
  // word array
  //////////////////////////////
  always_ff @(posedge cpu_clk) begin
    if (ram_en) begin
      if (req.write) begin
        for (int b = 0; b < fpga_pkg::strb_w; b++) begin
          if (req.wstrb[b]) begin
            mem[req.index][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
      end else begin
        // read data valid the cycle after the strobe
        ram_rdata <= mem[req.index];
      end
    end
  end

  //////////////////////////////
  // calibration model
  //////////////////////////////
  // counts from board reset and then stays done
  always_ff @(posedge cpu_clk or negedge rst_n) begin
    if (!rst_n) begin
      calib_cnt <= '0;
      calib_done <= 1'b0;
    end else if (!calib_done) begin
      calib_cnt <= calib_cnt + 1'b1;
      if (calib_cnt == fpga_pkg::calib_last) begin
        calib_done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ahb_bridge.sv ====
// single transfers only, no bursts; reads take one wait state and errors take two cycles
`timescale 1ns/10ps
`default_nettype none

module ahb_bridge (
  input  logic cpu_clk,
  input  logic periph_rst_n,
  input  logic hsel,
  input  logic [31:0] haddr,
  input  logic [1:0] htrans,
  input  logic hwrite,
  input  logic [2:0] hsize,
  input  logic [fpga_pkg::data_w-1:0] hwdata,
  input  logic hready,
  output logic hreadyout,
  output logic [fpga_pkg::data_w-1:0] hrdata,
  output logic hresp,
  output fpga_pkg::bus_req_t req,
  output logic ram_en,
  output logic gpio_en,
  input  logic [fpga_pkg::data_w-1:0] ram_rdata,
  input  logic [fpga_pkg::data_w-1:0] gpio_rdata
);

  typedef enum logic [1:0] {
    st_idle,
    st_rd_wait,
    st_err1,
    st_err2
  } phase_t;

  phase_t state;
  fpga_pkg::ahb_addr_u addr;
  logic accept;
  logic hit_ram;
  logic hit_gpio;
  logic size_ok;
  logic [fpga_pkg::strb_w-1:0] strb;
  logic wr_q;
  logic ram_q;
  logic [fpga_pkg::idx_w-1:0] index_q;
  logic [fpga_pkg::strb_w-1:0] strb_q;

  //////////////////////////////
  // address phase decode
  //////////////////////////////
  assign addr = haddr;
  assign accept = hsel && (htrans == fpga_pkg::htrans_nonseq) && hready && hreadyout;
  assign hit_ram = (addr.ram_view.tag == fpga_pkg::ram_tag);
  assign hit_gpio = (addr.gpio_view.tag == fpga_pkg::gpio_tag);
  assign size_ok = (hsize <= fpga_pkg::hsize_word);

  // data stays on its own byte lanes
  always_comb begin
    case (hsize)
      fpga_pkg::hsize_byte: strb = 4'b0001 << addr.ram_view.offset;
      fpga_pkg::hsize_half: strb = addr.ram_view.offset[1] ? 4'b1100 : 4'b0011;
      default: strb = 4'b1111;
    endcase
  end

  always_ff @(posedge cpu_clk) begin
    if (accept) begin
      ram_q <= hit_ram;
      index_q <= hit_ram ? addr.ram_view.index : {4'b0000, addr.gpio_view.index};
      strb_q <= strb;
    end
  end

  //////////////////////////////
  // data phase
  //////////////////////////////
  always_ff @(posedge cpu_clk or negedge periph_rst_n) begin
    if (!periph_rst_n) begin
      state <= st_idle;
      wr_q <= 1'b0;
    end else begin
      wr_q <= 1'b0;
      case (state)
        st_rd_wait: state <= st_idle;
        st_err1: state <= st_err2;
        default: begin
          state <= st_idle;
          if (accept) begin
            if (!size_ok || !(hit_ram || hit_gpio)) begin
              state <= st_err1;
            end else if (hwrite) begin
              wr_q <= 1'b1;
            end else begin
              state <= st_rd_wait;
            end
          end
        end
      endcase
    end
  end

  assign hreadyout = (state == st_idle) || (state == st_err2);
  assign hresp = (state == st_err1) || (state == st_err2);

  // write data arrives in the data phase, read strobe goes out in the wait cycle
  assign ram_en = (wr_q || (state == st_rd_wait)) && ram_q;
  assign gpio_en = (wr_q || (state == st_rd_wait)) && !ram_q;
  assign req = '{write: wr_q, index: index_q, wdata: hwdata, wstrb: strb_q};

  assign hrdata = ram_q ? ram_rdata : gpio_rdata;

endmodule

`default_nettype wire

// ==== rtl/reset_sequencer.sv ====
// peripherals stay in reset until calib_done; aux_reset must be synchronous to cpu_clk
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer (
  input  logic cpu_clk,
  input  logic rst_n,
  input  logic aux_reset,
  input  logic calib_done,
  output logic periph_rst_n,
  output logic sys_ready
);

  typedef enum logic [1:0] {
    st_wait_calib,
    st_hold,
    st_run
  } seq_state_t;

  seq_state_t state;
  seq_state_t state_nx;
  logic [fpga_pkg::hold_w-1:0] cnt;
  logic [fpga_pkg::hold_w-1:0] cnt_nx;

  //////////////////////////////
  // next state
  //////////////////////////////
  always_comb begin
    state_nx = state;
    cnt_nx = cnt;
    if (aux_reset && calib_done) begin
      // push button restarts the hold, ram stays calibrated
      state_nx = st_hold;
      cnt_nx = '0;
    end else begin
      case (state)
        st_wait_calib: begin
          // cnt is still zero here, so the first hold cycle counts as one
          if (calib_done) begin
            state_nx = st_hold;
            cnt_nx = cnt + 1'b1;
          end
        end
        st_hold: begin
          if (cnt == fpga_pkg::hold_last) begin
            state_nx = st_run;
          end else begin
            cnt_nx = cnt + 1'b1;
          end
        end
        default: begin
          state_nx = st_run;
        end
      endcase
    end
  end

  always_ff @(posedge cpu_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_wait_calib;
      cnt <= '0;
      periph_rst_n <= 1'b0;
    end else begin
      state <= state_nx;
      cnt <= cnt_nx;
      periph_rst_n <= (state_nx == st_run);
    end
  end

  assign sys_ready = (state == st_run);

endmodule

`default_nettype wire

// ==== rtl/fpga_pkg.sv ====
// assumes one clock domain and single AHB-Lite transfers; all sizes and addresses are fixed
`default_nettype none

package fpga_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;
  localparam int ram_words = 256;
  localparam int idx_w = $clog2(ram_words);
  localparam int gpo_w = 5;

  // calibration model of the ddr controller
  localparam int calib_cycles = 20;
  localparam int calib_w = $clog2(calib_cycles);
  localparam logic [calib_w-1:0] calib_last = calib_w'(calib_cycles - 1);

  // peripheral reset hold after calibration or push button
  localparam int rst_hold = 4;
  localparam int hold_w = $clog2(rst_hold);
  localparam logic [hold_w-1:0] hold_last = hold_w'(rst_hold - 1);

  //////////////////////////////
  // memory map
  //////////////////////////////
  // 1 KiB ram region at 0x8000_0000
  localparam logic [21:0] ram_tag = 22'h20_0000;
  // 64 byte gpio region at 0x1006_0000
  localparam logic [25:0] gpio_tag = 26'h040_1800;

  // gpio register indices
  localparam logic [idx_w-1:0] gpio_in_reg = 8'd0;
  localparam logic [idx_w-1:0] gpio_en_reg = 8'd1;
  localparam logic [idx_w-1:0] gpio_out_reg = 8'd2;

  //////////////////////////////
  // ahb codes
  //////////////////////////////
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [2:0] hsize_byte = 3'b000;
  localparam logic [2:0] hsize_half = 3'b001;
  localparam logic [2:0] hsize_word = 3'b010;

  // two readings of the same haddr word
  typedef struct packed {
    logic [21:0] tag;
    logic [7:0] index;
    logic [1:0] offset;
  } ram_addr_t;

  typedef struct packed {
    logic [25:0] tag;
    logic [3:0] index;
    logic [1:0] offset;
  } gpio_addr_t;

  typedef union packed {
    ram_addr_t ram_view;
    gpio_addr_t gpio_view;
  } ahb_addr_u;

  // request from the bridge to ram and gpio
  typedef struct packed {
    logic write;
    logic [idx_w-1:0] index;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
  } bus_req_t;

endpackage

`default_nettype wire
